//--- Makefile
TOP = host_io_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir

//--- compile.f
rtl/host_io_pkg.sv
rtl/ps2_pkg.sv
rtl/ps2_clk_gen.sv
rtl/ps2_device.sv
rtl/host_cmd_decoder.sv
rtl/host_io_top.sv
verification/ps2_host_bfm.sv
verification/host_io_tb.sv

//--- rtl/host_cmd_decoder.sv
////////////////////////////////////////////////////////////
// host frame decoder, config registers and read data
////////////////////////////////////////////////////////////

module host_cmd_decoder (
	input  logic                    clk_100,
	input  logic                    arst_n,
	input  host_io_pkg::host_req_t  req,
	output host_io_pkg::host_word_t rdata,
	output logic [1:0]              buttons,
	output host_io_pkg::host_word_t joystick_0,
	output host_io_pkg::host_word_t joystick_1,
	output logic [31:0]             status,
	output ps2_pkg::ps2_byte_t      kbd_wdata,
	output ps2_pkg::ps2_byte_t      mouse_wdata,
	output logic                    kbd_we,
	output logic                    mouse_we,
	output logic                    kbd_rd,
	output logic                    mouse_rd,
	input  ps2_pkg::ps2_rx_t        kbd_rx,
	input  ps2_pkg::ps2_rx_t        mouse_rx
);
	import host_io_pkg::*;

	// word index within the frame, saturating
	logic [3:0] word_cnt;
	host_word_t cmd;
	logic       arg_strobe;

	assign arg_strobe = req.enable && req.strobe && (word_cnt != 4'd0);

	// byte payload for the devices, qualified by we
	always_ff @(posedge clk_100) begin
		if (arg_strobe && (cmd == cmd_kbd))
			kbd_wdata <= req.din[7:0];
		if (arg_strobe && (cmd == cmd_mouse))
			mouse_wdata <= req.din[7:0];
	end

	always_ff @(posedge clk_100 or negedge arst_n) begin
		if (!arst_n) begin
			word_cnt   <= '0;
			cmd        <= '0;
			rdata      <= '0;
			buttons    <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			kbd_we     <= 1'b0;
			mouse_we   <= 1'b0;
			kbd_rd     <= 1'b0;
			mouse_rd   <= 1'b0;
		end else begin
			// single-cycle pulses
			kbd_we   <= 1'b0;
			mouse_we <= 1'b0;
			kbd_rd   <= 1'b0;
			mouse_rd <= 1'b0;

			if (!req.enable) begin
				word_cnt <= '0;
				rdata    <= '0;
			end else if (req.strobe) begin
				rdata <= '0;
				if (word_cnt != 4'hF)
					word_cnt <= word_cnt + 4'd1;

				if (word_cnt == 4'd0) begin
					cmd <= req.din;
				end else begin
					case (cmd)
						cmd_cfg:   buttons    <= req.din[1:0];
						cmd_joy0:  joystick_0 <= req.din;
						cmd_joy1:  joystick_1 <= req.din;
						cmd_mouse: mouse_we   <= 1'b1;
						cmd_kbd:   kbd_we     <= 1'b1;
						cmd_status: begin
							if (word_cnt == 4'd1)
								status[15:0] <= req.din;
							else if (word_cnt == 4'd2)
								status[31:16] <= req.din;
						end
						// rx byte with its valid flag on bit 8
						cmd_ps2_read: begin
							if (word_cnt == 4'd1) begin
								rdata  <= {7'd0, kbd_rx};
								kbd_rd <= 1'b1;
							end else if (word_cnt == 4'd2) begin
								rdata    <= {7'd0, mouse_rx};
								mouse_rd <= 1'b1;
							end
						end
						default: ;
					endcase
				end
			end
		end
	end

endmodule

//--- rtl/host_io_pkg.sv
////////////////////////////////////////////////////////////
// host bus types: bus word, command codes, request bundle
////////////////////////////////////////////////////////////

package host_io_pkg;

	// one word on the host strobe bus
	typedef logic [15:0] host_word_t;

	// command codes carried by the first word of a frame
	typedef enum host_word_t {
		// button/config byte
		cmd_cfg      = 16'h0001,
		cmd_joy0     = 16'h0002,
		cmd_joy1     = 16'h0003,
		// byte for the emulated mouse
		cmd_mouse    = 16'h0004,
		// byte for the emulated keyboard
		cmd_kbd      = 16'h0005,
		// status, low half then high half
		cmd_status   = 16'h001E,
		// keyboard rx at word 1, mouse rx at word 2
		cmd_ps2_read = 16'h0021
	} host_cmd_t;

	// host request, level plus strobe plus data
	typedef struct packed {
		// high for the whole frame
		logic       enable;
		// one cycle per word
		logic       strobe;
		host_word_t din;
	} host_req_t;

endpackage

//--- rtl/host_io_top.sv
////////////////////////////////////////////////////////////
// host I/O bridge: command decoder plus keyboard and mouse
////////////////////////////////////////////////////////////

module host_io_top #(
	parameter int PS2_DIV   = 2000,
	parameter int FIFO_BITS = 5
) (
	input  logic                    clk_100,
	input  logic                    arst_n,
	input  host_io_pkg::host_req_t  req,
	output host_io_pkg::host_word_t rdata,
	output logic [1:0]              buttons,
	output host_io_pkg::host_word_t joystick_0,
	output host_io_pkg::host_word_t joystick_1,
	output logic [31:0]             status,
	output ps2_pkg::ps2_pins_t      kbd_pins_out,
	input  ps2_pkg::ps2_pins_t      kbd_pins_in,
	output ps2_pkg::ps2_pins_t      mouse_pins_out,
	input  ps2_pkg::ps2_pins_t      mouse_pins_in
);
	import ps2_pkg::*;

	ps2_byte_t kbd_wdata;
	ps2_byte_t mouse_wdata;
	logic      kbd_we;
	logic      mouse_we;
	logic      kbd_rd;
	logic      mouse_rd;
	ps2_rx_t   kbd_rx;
	ps2_rx_t   mouse_rx;
	logic      ps2_clk;

	host_cmd_decoder decoder (
		.clk_100     (clk_100),
		.arst_n      (arst_n),
		.req         (req),
		.rdata       (rdata),
		.buttons     (buttons),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.status      (status),
		.kbd_wdata   (kbd_wdata),
		.mouse_wdata (mouse_wdata),
		.kbd_we      (kbd_we),
		.mouse_we    (mouse_we),
		.kbd_rd      (kbd_rd),
		.mouse_rd    (mouse_rd),
		.kbd_rx      (kbd_rx),
		.mouse_rx    (mouse_rx)
	);

	// one bit clock for both devices
	ps2_clk_gen #(
		.PS2_DIV (PS2_DIV)
	) clk_gen (
		.clk_100 (clk_100),
		.arst_n  (arst_n),
		.ps2_clk (ps2_clk)
	);

	ps2_device #(
		.FIFO_BITS (FIFO_BITS)
	) keyboard (
		.clk_100  (clk_100),
		.arst_n   (arst_n),
		.ps2_clk  (ps2_clk),
		.wdata    (kbd_wdata),
		.we       (kbd_we),
		.pins_out (kbd_pins_out),
		.pins_in  (kbd_pins_in),
		.rx       (kbd_rx),
		.rd       (kbd_rd)
	);

	ps2_device #(
		.FIFO_BITS (FIFO_BITS)
	) mouse (
		.clk_100  (clk_100),
		.arst_n   (arst_n),
		.ps2_clk  (ps2_clk),
		.wdata    (mouse_wdata),
		.we       (mouse_we),
		.pins_out (mouse_pins_out),
		.pins_in  (mouse_pins_in),
		.rx       (mouse_rx),
		.rd       (mouse_rd)
	);

endmodule

//--- rtl/ps2_clk_gen.sv
////////////////////////////////////////////////////////////
// PS/2 bit clock, divided level shared by both devices
////////////////////////////////////////////////////////////

module ps2_clk_gen #(
	parameter int PS2_DIV = 2000
) (
	input  logic clk_100,
	input  logic arst_n,
	output logic ps2_clk
);

	localparam int CNT_W = (PS2_DIV > 0) ? $clog2(PS2_DIV + 1) : 1;

	logic [CNT_W-1:0] cnt;

	// level flips once every PS2_DIV+1 cycles
	always_ff @(posedge clk_100 or negedge arst_n) begin
		if (!arst_n) begin
			cnt     <= '0;
			ps2_clk <= 1'b0;
		end else begin
			if (cnt == CNT_W'(PS2_DIV)) begin
				cnt     <= '0;
				ps2_clk <= ~ps2_clk;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

//--- rtl/ps2_device.sv
////////////////////////////////////////////////////////////
// emulated PS/2 device: byte FIFO, frame transmitter,
// host-to-device receiver and clock line drive
////////////////////////////////////////////////////////////

module ps2_device #(
	parameter int FIFO_BITS = 5
) (
	input  logic               clk_100,
	input  logic               arst_n,
	input  logic               ps2_clk,
	input  ps2_pkg::ps2_byte_t wdata,
	input  logic               we,
	output ps2_pkg::ps2_pins_t pins_out,
	input  ps2_pkg::ps2_pins_t pins_in,
	output ps2_pkg::ps2_rx_t   rx,
	input  logic               rd
);
	import ps2_pkg::*;

	ps2_byte_t            fifo [1 << FIFO_BITS];
	logic [FIFO_BITS-1:0] wptr;
	logic [FIFO_BITS-1:0] rptr;

	ps2_tx_state_t tx_state;
	ps2_rx_state_t rx_state;
	ps2_byte_t     tx_byte;
	logic [2:0]    tx_cnt;
	logic [3:0]    rx_cnt;
	logic          parity;
	logic [1:0]    holdoff;

	logic       old_clk;
	logic [1:0] clk_sync;
	logic       dat_sync;

	logic clk_rise;
	logic clk_fall;
	logic lines_idle;
	logic host_req;
	logic tx_load;
	logic tx_shift;
	logic busy;

	assign clk_rise = ps2_clk & ~old_clk;
	assign clk_fall = ~ps2_clk & old_clk;

	// open-drain line, low if either side pulls it down
	assign lines_idle = clk_sync[1] & clk_sync[0] & dat_sync;

	// host pulls data low and releases the clock
	assign host_req = (rx_state == rx_idle) && (tx_state == tx_idle) &&
	                  clk_sync[0] && !clk_sync[1] && !dat_sync;

	assign tx_load  = clk_rise && (rx_state == rx_idle) && (tx_state == tx_idle) &&
	                  lines_idle && (wptr != rptr) && (holdoff == 2'd0);
	assign tx_shift = clk_rise && (rx_state == rx_idle) && (tx_state == tx_data);

	// clock is only pulsed while a frame is in flight
	assign busy = (tx_state != tx_idle) || ((rx_state != rx_idle) && (rx_state != rx_req));

	always_ff @(posedge clk_100) begin
		if (we)
			fifo[wptr] <= wdata;
	end

	always_ff @(posedge clk_100) begin
		if (tx_load)
			tx_byte <= fifo[rptr];
		else if (tx_shift)
			tx_byte <= {1'b0, tx_byte[7:1]};
	end

	////////////////////////////////////////////////////////////
	// frame control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_100 or negedge arst_n) begin
		if (!arst_n) begin
			wptr     <= '0;
			rptr     <= '0;
			tx_state <= tx_idle;
			rx_state <= rx_idle;
			tx_cnt   <= '0;
			rx_cnt   <= '0;
			parity   <= 1'b1;
			holdoff  <= 2'd2;
			old_clk  <= 1'b0;
			clk_sync <= 2'b11;
			dat_sync <= 1'b1;
			pins_out <= '{clk: 1'b1, dat: 1'b1};
			rx       <= '0;
		end else begin
			old_clk  <= ps2_clk;
			clk_sync <= {clk_sync[0], pins_in.clk & pins_out.clk};
			dat_sync <= pins_in.dat & pins_out.dat;

			if (we)
				wptr <= wptr + 1'b1;
			if (rd)
				rx.valid <= 1'b0;

			if (host_req) begin
				rx_state     <= rx_req;
				pins_out.dat <= 1'b1;
			end else if (clk_rise) begin
				case (rx_state)
					rx_req: begin
						rx_state <= rx_data;
						rx_cnt   <= '0;
					end
					// 8 data bits, then skip the parity bit
					rx_data: begin
						if (rx_cnt <= 4'd7)
							rx.data <= {dat_sync, rx.data[7:1]};
						else
							rx_state <= rx_stop;
						rx_cnt <= rx_cnt + 4'd1;
					end
					rx_stop: begin
						if (dat_sync) begin
							rx_state     <= rx_ack;
							pins_out.dat <= 1'b0;
						end
					end
					rx_ack: begin
						pins_out.dat <= 1'b1;
						rx.valid     <= 1'b1;
						rx_state     <= rx_idle;
					end
					default: begin
						// receiver idle, transmitter may run
						case (tx_state)
							tx_idle: begin
								if (tx_load) begin
									rptr         <= rptr + 1'b1;
									parity       <= 1'b1;
									tx_cnt       <= '0;
									holdoff      <= 2'd2;
									tx_state     <= tx_data;
									// start bit
									pins_out.dat <= 1'b0;
								end else if (lines_idle && (wptr != rptr)) begin
									holdoff <= holdoff - 2'd1;
								end
							end
							tx_data: begin
								pins_out.dat <= tx_byte[0];
								parity       <= parity ^ tx_byte[0];
								tx_cnt       <= tx_cnt + 3'd1;
								if (tx_cnt == 3'd7)
									tx_state <= tx_parity;
							end
							tx_parity: begin
								pins_out.dat <= parity;
								tx_state     <= tx_stop;
							end
							tx_stop: begin
								pins_out.dat <= 1'b1;
								tx_state     <= tx_done;
							end
							default: tx_state <= tx_idle;
						endcase
					end
				endcase
			end

			if (clk_rise)
				pins_out.clk <= 1'b1;
			else if (clk_fall)
				pins_out.clk <= busy ? ps2_clk : 1'b1;
		end
	end

endmodule

//--- rtl/ps2_pkg.sv
////////////////////////////////////////////////////////////
// PS/2 device types: byte, pin pair, rx byte, FSM states
////////////////////////////////////////////////////////////

package ps2_pkg;

	typedef logic [7:0] ps2_byte_t;

	// clock/data pair, same layout for in and out
	typedef struct packed {
		logic clk;
		logic dat;
	} ps2_pins_t;

	// byte received from the core side
	typedef struct packed {
		logic      valid;
		ps2_byte_t data;
	} ps2_rx_t;

	typedef enum logic [3:0] {
		tx_idle,
		tx_data,
		tx_parity,
		tx_stop,
		// one extra period after the stop bit
		tx_done
	} ps2_tx_state_t;

	typedef enum logic [2:0] {
		rx_idle,
		rx_req,
		rx_data,
		rx_stop,
		rx_ack
	} ps2_rx_state_t;

endpackage

//--- verification/host_io_tb.sv
////////////////////////////////////////////////////////////
// testbench for the host I/O bridge
////////////////////////////////////////////////////////////

module host_io_tb;
	import host_io_pkg::*;
	import ps2_pkg::*;

	localparam int PS2_DIV = 4;
	// frames x bits x bit period plus margin for holdoff and host frames
	localparam int TIMEOUT_CYCLES = 12 * 11 * 2 * (PS2_DIV + 1) + 1500;

	logic       clk_100;
	logic       arst_n;
	host_req_t  req;
	host_word_t rdata;
	logic [1:0] buttons;
	host_word_t joystick_0;
	host_word_t joystick_1;
	logic [31:0] status;
	ps2_pins_t  kbd_pins_out;
	ps2_pins_t  kbd_pins_in;
	ps2_pins_t  mouse_pins_out;
	ps2_pins_t  mouse_pins_in;
	int         kbd_bad;
	int         kbd_n;
	int         mouse_bad;
	int         mouse_n;

	// expected values and check windows
	logic        check_regs;
	logic        check_rd;
	logic        mouse_quiet;
	logic [1:0]  exp_buttons;
	host_word_t  exp_joy0;
	host_word_t  exp_joy1;
	logic [31:0] exp_status;
	host_word_t  exp_rdata;

	int errors;
	int tests_run;
	int tests_failed;
	int cycles;

	host_io_top #(
		.PS2_DIV   (PS2_DIV),
		.FIFO_BITS (5)
	) DUT (
		.clk_100        (clk_100),
		.arst_n         (arst_n),
		.req            (req),
		.rdata          (rdata),
		.buttons        (buttons),
		.joystick_0     (joystick_0),
		.joystick_1     (joystick_1),
		.status         (status),
		.kbd_pins_out   (kbd_pins_out),
		.kbd_pins_in    (kbd_pins_in),
		.mouse_pins_out (mouse_pins_out),
		.mouse_pins_in  (mouse_pins_in)
	);

	ps2_host_bfm #(.NAME("keyboard")) kbd_bfm (
		.clk_100 (clk_100),
		.dev_out (kbd_pins_out),
		.drive   (kbd_pins_in),
		.bad_frames (kbd_bad),
		.n_rx    (kbd_n)
	);

	ps2_host_bfm #(.NAME("mouse")) mouse_bfm (
		.clk_100 (clk_100),
		.dev_out (mouse_pins_out),
		.drive   (mouse_pins_in),
		.bad_frames (mouse_bad),
		.n_rx    (mouse_n)
	);

	always #2 clk_100 = ~clk_100;

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR %0t: %s", $time, msg);
	endtask

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	assert property (@(posedge clk_100) disable iff (!arst_n)
		check_regs |-> (buttons == exp_buttons && joystick_0 == exp_joy0 &&
		                joystick_1 == exp_joy1 && status == exp_status))
		else report_error("config outputs differ from written values");

	assert property (@(posedge clk_100) disable iff (!arst_n)
		check_rd |-> (rdata == exp_rdata))
		else report_error($sformatf("rdata %h, expected %h", rdata, exp_rdata));

	// rdata cleared while no frame is open
	assert property (@(posedge clk_100) disable iff (!arst_n)
		!req.enable |=> (rdata == 16'h0000))
		else report_error("rdata not zero outside a frame");

	assert property (@(posedge clk_100) disable iff (!arst_n)
		mouse_quiet |-> (mouse_pins_out == 2'b11))
		else report_error("mouse lines active during keyboard transfer");

	assert property (@(posedge clk_100) disable iff (!arst_n)
		$stable(kbd_bad) && $stable(mouse_bad))
		else report_error("PS/2 host model saw a bad frame");

	////////////////////////////////////////////////////////////
	// host bus tasks
	////////////////////////////////////////////////////////////

	task automatic open_frame();
		@(negedge clk_100);
		req.enable = 1'b1;
	endtask

	task automatic close_frame();
		@(negedge clk_100);
		req.enable = 1'b0;
	endtask

	task automatic send_word(input host_word_t w);
		@(negedge clk_100);
		req.strobe = 1'b1;
		req.din    = w;
		@(negedge clk_100);
		req.strobe = 1'b0;
	endtask

	// strobe a word and check rdata in the following cycle
	task automatic read_word(input host_word_t w, input host_word_t expect_val);
		send_word(w);
		exp_rdata = expect_val;
		check_rd  = 1'b1;
		@(negedge clk_100);
		check_rd  = 1'b0;
	endtask

	task automatic pulse_reg_check();
		check_regs = 1'b1;
		@(negedge clk_100);
		check_regs = 1'b0;
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (errors != errors_before) begin
			tests_failed++;
			$display("%s: fail", name);
		end else begin
			$display("%s: pass", name);
		end
	endtask

	task automatic compare_byte(input ps2_byte_t got, input ps2_byte_t want);
		assert (got == want)
			else report_error($sformatf("PS/2 byte %h, expected %h", got, want));
	endtask

	always @(posedge clk_100) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		int         e0;
		host_word_t w;
		host_word_t lo;
		ps2_byte_t  b;
		ps2_byte_t  mb[4];

		void'($urandom(32'h436f_390f));
		clk_100     = 1'b0;
		arst_n      = 1'b0;
		req         = '0;
		check_regs  = 1'b0;
		check_rd    = 1'b0;
		mouse_quiet = 1'b0;
		exp_buttons = '0;
		exp_joy0    = '0;
		exp_joy1    = '0;
		exp_status  = '0;
		exp_rdata   = '0;
		errors      = 0;
		tests_run   = 0;
		tests_failed = 0;
		cycles      = 0;
		repeat (3) @(negedge clk_100);
		arst_n = 1'b1;

		// rdata idle and unknown command
		e0 = errors;
		exp_rdata = 16'h0000;
		check_rd  = 1'b1;
		@(negedge clk_100);
		check_rd  = 1'b0;
		pulse_reg_check();
		open_frame();
		read_word(16'h007F, 16'h0000);
		read_word(16'(($urandom)), 16'h0000);
		read_word(16'(($urandom)), 16'h0000);
		close_frame();
		end_test("rdata_idle", e0);

		// config, joysticks and status
		e0 = errors;
		w = 16'($urandom);
		open_frame();
		send_word(cmd_cfg);
		send_word(w);
		exp_buttons = w[1:0];
		pulse_reg_check();
		close_frame();
		w = 16'($urandom);
		open_frame();
		send_word(cmd_joy0);
		send_word(w);
		exp_joy0 = w;
		pulse_reg_check();
		close_frame();
		w = 16'($urandom);
		open_frame();
		send_word(cmd_joy1);
		send_word(w);
		exp_joy1 = w;
		pulse_reg_check();
		close_frame();
		lo = 16'($urandom);
		w  = 16'($urandom);
		open_frame();
		send_word(cmd_status);
		send_word(lo);
		send_word(w);
		exp_status = {w, lo};
		pulse_reg_check();
		close_frame();
		end_test("config_regs", e0);

		// one keyboard byte while the mouse stays quiet
		e0 = errors;
		b = 8'($urandom);
		mouse_quiet = 1'b1;
		open_frame();
		send_word(cmd_kbd);
		send_word({8'h00, b});
		close_frame();
		wait (kbd_n == 1);
		@(negedge clk_100);
		mouse_quiet = 1'b0;
		compare_byte(kbd_bfm.next_byte(), b);
		end_test("kbd_tx", e0);

		// four mouse bytes in order
		e0 = errors;
		open_frame();
		send_word(cmd_mouse);
		for (int i = 0; i < 4; i++) begin
			mb[i] = 8'($urandom);
			send_word({8'h00, mb[i]});
		end
		close_frame();
		wait (mouse_n == 4);
		@(negedge clk_100);
		for (int i = 0; i < 4; i++)
			compare_byte(mouse_bfm.next_byte(), mb[i]);
		end_test("mouse_tx", e0);

		// host-to-device byte and read back
		e0 = errors;
		b = 8'($urandom);
		kbd_bfm.send_byte(b);
		wait (DUT.kbd_rx.valid);
		// unknown command sharing the low byte of the PS/2 read
		open_frame();
		read_word(16'h0121, 16'h0000);
		read_word(16'h0000, 16'h0000);
		close_frame();
		// frame ends with the received byte still on rdata
		open_frame();
		send_word(cmd_ps2_read);
		read_word(16'h0000, 16'h0100 | {8'h00, b});
		close_frame();
		open_frame();
		send_word(cmd_ps2_read);
		read_word(16'h0000, {8'h00, b});
		read_word(16'h0000, 16'h0000);
		close_frame();
		end_test("kbd_rx", e0);

		repeat (4) @(negedge clk_100);
		$display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- verification/ps2_host_bfm.sv
////////////////////////////////////////////////////////////
// behavioural PS/2 host, decodes device frames and sends
// host-to-device bytes
////////////////////////////////////////////////////////////

module ps2_host_bfm #(
	parameter string NAME = "ps2"
) (
	input  logic               clk_100,
	input  ps2_pkg::ps2_pins_t dev_out,
	output ps2_pkg::ps2_pins_t drive,
	output int                 bad_frames,
	output int                 n_rx
);
	import ps2_pkg::*;

	ps2_byte_t  rx_q[$];
	logic [10:0] bits;
	int          bit_cnt;
	logic        sending;
	logic        dev_clk;

	assign dev_clk = dev_out.clk;

	initial begin
		drive      = '{clk: 1'b1, dat: 1'b1};
		bad_frames = 0;
		n_rx       = 0;
		bit_cnt    = 0;
		sending    = 1'b0;
	end

	// device frames: start, 8 data LSB first, odd parity, stop
	always @(negedge dev_clk) begin
		if (!sending) begin
			bits[bit_cnt] = dev_out.dat & drive.dat;
			bit_cnt++;
			if (bit_cnt == 11) begin
				bit_cnt = 0;
				if (bits[0] !== 1'b0 || (^bits[9:1]) !== 1'b1 || bits[10] !== 1'b1) begin
					$display("%s: bad device frame %b at %0t", NAME, bits, $time);
					bad_frames++;
				end
				rx_q.push_back(bits[8:1]);
				n_rx++;
			end
		end
	end

	function automatic ps2_byte_t next_byte();
		if (rx_q.size() == 0)
			return 8'h00;
		return rx_q.pop_front();
	endfunction

	// inhibit, request, then clock the byte out on device clock
	task automatic send_byte(input ps2_byte_t b);
		logic [9:0] frame;
		frame   = {1'b1, ~^b, b};
		sending = 1'b1;
		@(negedge clk_100);
		drive.clk = 1'b0;
		repeat (4) @(negedge clk_100);
		drive.dat = 1'b0;
		repeat (2) @(negedge clk_100);
		drive.clk = 1'b1;
		for (int i = 0; i < 10; i++) begin
			@(negedge dev_clk);
			@(negedge clk_100);
			drive.dat = frame[i];
		end
		@(negedge dev_clk);
		if (dev_out.dat !== 1'b0) begin
			$display("%s: device did not acknowledge the byte at %0t", NAME, $time);
			bad_frames++;
		end
		@(posedge dev_clk);
		sending = 1'b0;
	endtask

endmodule
